// File: tb.f
design/dds_pkg.sv
design/key_wave_sel.sv
design/dds_phase.sv
design/wave_rom.sv
design/top_dds.sv
verif/dds_props.sv
verif/dds_checker.sv
verif/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the DDS testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_top_sim

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "test passed" "$LOG"; then
  echo "no pass message in $LOG"
  exit 1
fi
exit 0

// File: verif/tb_top.sv
`default_nettype none

module tb_top;

  import dds_pkg::*;

  localparam logic [31:0] freq_ctrl       = 32'd42949 * 32'd97;  // fast sweep
  localparam logic [11:0] phase_ctrl      = 12'd1024;
  localparam int          debounce_cycles = 20;
  localparam int          sweep_cycles    = 2200;   // two accumulator wraps
  localparam int          n_items         = 12;

  // one stretch of constant key level
  typedef struct packed {
    logic        key;                               // level on key_n
    logic        mark;                              // compare selection after it
    logic        press;                             // item held a clean press
    logic [15:0] len;                               // cycles
  } seg_t;

  logic         sys_clk;
  logic         sys_rst_n;
  logic         key_n;
  wave_onehot_t wave_sel;
  sample_t      data_out;
  wave_onehot_t exp_sel;                            // press model
  logic         sel_chk;
  logic         sel_press;
  logic         sweep_done;
  logic         run_done;
  int           err_total;
  int           chk_total;
  int           seed        = 32'hff3d;
  int           cycles      = 0;
  int           cycle_limit = 0;
  int           total;
  seg_t         segs [$];

  top_dds #(
    .freq_ctrl       (freq_ctrl),
    .phase_ctrl      (phase_ctrl),
    .debounce_cycles (debounce_cycles)
  ) u_dut (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .key_n     (key_n),
    .wave_sel  (wave_sel),
    .data_out  (data_out)
  );

  dds_checker #(
    .freq_ctrl  (freq_ctrl),
    .phase_ctrl (phase_ctrl)
  ) u_chk (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .wave_sel   (wave_sel),
    .data_out   (data_out),
    .exp_sel    (exp_sel),
    .sel_chk    (sel_chk),
    .sel_press  (sel_press),
    .sweep_done (sweep_done),
    .run_done   (run_done),
    .err_total  (err_total),
    .chk_total  (chk_total)
  );

  initial
  begin
    sys_clk = 1'b0;
    forever #4 sys_clk = ~sys_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus planning
  //////////////////////////////////////////////////////////////////////

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  task automatic add_seg(input logic key, input logic mark, input logic press, input int len);
    segs.push_back('{key: key, mark: mark, press: press, len: 16'(len)});
  endtask

  // short glitches that never pass the debounce and end high
  task automatic add_burst();
    int n;
    n = rand_range(1, 4);
    repeat (n)
    begin
      add_seg(1'b0, 1'b0, 1'b0, rand_range(1, debounce_cycles - 3));
      add_seg(1'b1, 1'b0, 1'b0, rand_range(1, debounce_cycles - 3));
    end
  endtask

  task automatic plan_item(input logic clean);
    add_burst();
    add_seg(1'b1, 1'b0, 1'b0, rand_range(debounce_cycles + 5, debounce_cycles + 20));
    if (clean)
    begin
      add_seg(1'b0, 1'b0, 1'b0, rand_range(debounce_cycles + 5, debounce_cycles + 35));
      add_burst();                                  // release bounce
    end
    else
      add_seg(1'b0, 1'b0, 1'b0, rand_range(1, debounce_cycles - 3));  // short press
    add_seg(1'b1, 1'b1, clean, rand_range(debounce_cycles + 5, debounce_cycles + 30));
  endtask

  // entered and left 1 unit after a rising edge
  task automatic drive_seg(input seg_t s);
    key_n = s.key;
    repeat (s.len) @(posedge sys_clk);
    #1;
    if (s.mark)
    begin
      if (s.press)
        exp_sel = {exp_sel[2:0], exp_sel[3]};       // one step per clean press
      sel_press = s.press;
      sel_chk   = 1'b1;
      @(posedge sys_clk);
      #1 sel_chk = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    key_n      = 1'b1;
    sys_rst_n  = 1'b1;
    exp_sel    = sel_sin;
    sel_chk    = 1'b0;
    sel_press  = 1'b0;
    sweep_done = 1'b0;
    run_done   = 1'b0;

    for (int i = 0; i < n_items; i++)
      plan_item(i % 3 != 2);                        // two presses and then a bounce-only item
    total = 16 + sweep_cycles + 8;
    foreach (segs[i])
      total += int'(segs[i].len) + int'(segs[i].mark);
    cycle_limit = total + 200;

    #1 sys_rst_n = 1'b0;                            // falling edge ahead of the first clock
    repeat (16) @(posedge sys_clk);
    #1 sys_rst_n = 1'b1;
    repeat (sweep_cycles) @(posedge sys_clk);
    #1 sweep_done = 1'b1;

    foreach (segs[i])
      drive_seg(segs[i]);

    repeat (4) @(posedge sys_clk);                  // last samples reach the checker
    #1 run_done = 1'b1;
    repeat (2) @(posedge sys_clk);

    $display("checks %0d errors %0d", chk_total, err_total);
    if (err_total == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // watchdog
  always @(posedge sys_clk)
  begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit)
    begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verif/dds_checker.sv
`default_nettype none

module dds_checker #(
  parameter logic [31:0]                 freq_ctrl  = 32'd65535,
  parameter logic [dds_pkg::phase_w-1:0] phase_ctrl = 12'd1024
) (
  input  wire logic                  sys_clk,
  input  wire logic                  sys_rst_n,
  input  wire dds_pkg::wave_onehot_t wave_sel,
  input  wire dds_pkg::sample_t      data_out,
  input  wire dds_pkg::wave_onehot_t exp_sel,    // from the press model
  input  wire logic                  sel_chk,    // compare selection this cycle
  input  wire logic                  sel_press,  // item held a clean press
  input  wire logic                  sweep_done,
  input  wire logic                  run_done,
  output int                         err_total,
  output int                         chk_total
);

  import dds_pkg::*;

  localparam int n_tests  = 5;
  localparam int t_reset  = 0;
  localparam int t_sweep  = 1;
  localparam int t_press  = 2;
  localparam int t_bounce = 3;
  localparam int t_shape  = 4;

  int           k = -1;                             // edges since reset release, -1 before reset
  int           chk_cnt [n_tests] = '{default: 0};
  int           err_cnt [n_tests] = '{default: 0};
  int           errs = 0;
  int           chks = 0;
  int           p;
  wave_e        w;
  wave_onehot_t sel_d1, sel_d2, sel_d3, sel_d4;     // wave_sel 1..4 samples back
  logic         reset_shown = 1'b0;
  logic         sweep_shown = 1'b0;
  logic         run_shown   = 1'b0;

  assign err_total = errs;
  assign chk_total = chks;

  function automatic string test_name(int t);
    case (t)
      t_reset:  return "reset_state";
      t_sweep:  return "phase_sweep";
      t_press:  return "press_rotation";
      t_bounce: return "bounce_reject";
      default:  return "wave_shapes";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // p(k) = (((k-3)*f >> 20) + offset) mod 4096
  function automatic int phase_at(int kk);
    logic [31:0] acc;
    logic [11:0] code;
    acc  = 32'(kk - 3) * freq_ctrl;                 // wraps at 2^32
    code = acc[31:20] + phase_ctrl;                 // mod 4096
    return int'(code);
  endfunction

  function automatic wave_e sel_to_wave(wave_onehot_t s);
    case (s)
      4'b0010: return wave_squ;
      4'b0100: return wave_tri;
      4'b1000: return wave_saw;
      default: return wave_sin;                     // illegal reads as sine
    endcase
  endfunction

  function automatic int expect_sample(wave_e wv, int ph);
    real r;
    case (wv)
      wave_sin:
      begin
        r = 127.5 + 127.5 * $sin(6.283185307179586 * ph / 4096.0);
        return $rtoi(r + 0.5);
      end
      wave_squ: return (ph < 2048) ? 255 : 0;
      wave_tri: return (ph < 2048) ? ph / 8 : (4095 - ph) / 8;
      default:  return ph / 16;
    endcase
  endfunction

  task automatic compare(input int t, input int exp_v, input int act_v, input int tol);
    chk_cnt[t]++;
    chks++;
    if (act_v > exp_v + tol || act_v < exp_v - tol)
    begin
      err_cnt[t]++;
      errs++;
      $display("MISMATCH %s k=%0d expected %0d actual %0d", test_name(t), k, exp_v, act_v);
    end
  endtask

  task automatic show(input int t);
    if (chk_cnt[t] == 0)
    begin
      errs++;
      $display("%s made no checks at all", test_name(t));
    end
    else
      $display("%s: checks %0d errors %0d %s", test_name(t), chk_cnt[t], err_cnt[t],
               (err_cnt[t] == 0) ? "ok" : "FAIL");
  endtask

  //////////////////////////////////////////////////////////////////////
  // edge count and compares
  //////////////////////////////////////////////////////////////////////

  always @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      k <= 0;
    else
      k <= k + 1;
  end

  // outputs settle after the rising edge so sample on the falling one
  always @(negedge sys_clk)
  begin
    if (!sys_rst_n || k == 0)
    begin
      compare(t_reset, int'(sel_sin), int'(wave_sel), 0);
      compare(t_reset, 0, int'(data_out), 0);
    end
    else if (k == 1)
      compare(t_reset, int'(sel_sin), int'(wave_sel), 0);

    if (sys_rst_n && k >= 3)
    begin
      p = phase_at(k);
      w = sel_to_wave(sel_d2);                      // selection two edges back
      if (!sweep_done)
        compare(t_sweep, expect_sample(wave_sin, p), int'(data_out), 1);
      else if (sel_d2 == sel_d3 && sel_d3 == sel_d4)
        compare(t_shape, expect_sample(w, p), int'(data_out), (w == wave_sin) ? 1 : 0);
    end

    if (sel_chk)
      compare(sel_press ? t_press : t_bounce, int'(exp_sel), int'(wave_sel), 0);

    sel_d4 = sel_d3;
    sel_d3 = sel_d2;
    sel_d2 = sel_d1;
    sel_d1 = wave_sel;

    if (k == 2 && !reset_shown)
    begin
      show(t_reset);
      reset_shown = 1'b1;
    end
    if (sweep_done && !sweep_shown)
    begin
      show(t_sweep);
      sweep_shown = 1'b1;
    end
    if (run_done && !run_shown)
    begin
      show(t_press);
      show(t_bounce);
      show(t_shape);
      run_shown = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verif/dds_props.sv
`default_nettype none

module dds_props (
  input wire logic                  sys_clk,
  input wire logic                  sys_rst_n,
  input wire dds_pkg::wave_onehot_t wave_sel,
  input wire dds_pkg::sample_t      data_out
);

  import dds_pkg::*;

  // leds always show exactly one waveform
  a_sel_onehot: assert property (@(posedge sys_clk) $onehot(wave_sel))
    else $error("wave_sel is not one-hot");

  // reset holds sine and a zero sample
  a_reset_state: assert property (@(posedge sys_clk)
      !sys_rst_n |-> (wave_sel == sel_sin && data_out == '0))
    else $error("wave_sel or data_out wrong while reset is held");

  // any change is a single left rotation
  a_sel_step: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
      (wave_sel != $past(wave_sel))
      |-> (wave_sel == {$past(wave_sel[2:0]), $past(wave_sel[3])}))
    else $error("wave_sel moved by more than one step");

endmodule

bind top_dds dds_props u_props (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .wave_sel  (wave_sel),
  .data_out  (data_out)
);

`default_nettype wire

// File: design/top_dds.sv
`default_nettype none

module top_dds #(
  parameter logic [31:0]                 freq_ctrl       = 32'd65535,
  parameter logic [dds_pkg::phase_w-1:0] phase_ctrl      = 12'd1024,
  parameter int                          debounce_cycles = 50000   // 1 ms at 50 MHz
) (
  input  wire logic                  sys_clk,
  input  wire logic                  sys_rst_n,
  input  wire logic                  key_n,        // button, low when pressed
  output wire dds_pkg::wave_onehot_t wave_sel,     // leds
  output wire dds_pkg::sample_t      data_out      // to the dac
);

  import dds_pkg::*;

  rom_addr_u rom_addr;                              // phase block -> rom

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  key_wave_sel #(
    .debounce_cycles (debounce_cycles)
  ) u_key_wave_sel (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .key_n     (key_n),
    .wave_sel  (wave_sel)                           // also feeds the decode below
  );

  dds_phase #(
    .freq_ctrl  (freq_ctrl),
    .phase_ctrl (phase_ctrl)
  ) u_dds_phase (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .wave_sel  (wave_sel),
    .rom_addr  (rom_addr)
  );

  wave_rom u_wave_rom (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .rom_addr  (rom_addr),
    .data_out  (data_out)
  );

endmodule

`default_nettype wire

// File: design/wave_rom.sv
`default_nettype none

module wave_rom (
  input  wire logic               sys_clk,
  input  wire logic               sys_rst_n,
  input  wire dds_pkg::rom_addr_u rom_addr,        // {wave, phase}
  output dds_pkg::sample_t        data_out         // registered dac sample
);

  import dds_pkg::*;

  localparam real two_pi = 6.283185307179586;

  sample_t rom_mem [rom_depth];                     // four tables back to back

  //////////////////////////////////////////////////////////////////////
  // table contents
  //////////////////////////////////////////////////////////////////////

  // one sample for waveform w at phase p
  function automatic sample_t wave_sample(wave_e w, int p);
    real s;
    case (w)
      wave_sin:
      begin
        s = 127.5 + 127.5 * $sin(two_pi * p / table_depth);
        return sample_t'($rtoi(s + 0.5));           // round to nearest
      end
      wave_squ:
        return (p < table_depth / 2) ? sample_t'(255) : sample_t'(0);
      wave_tri:                                     // up then down, p/8 steps
        if (p < table_depth / 2)
          return sample_t'(p >> (phase_w - sample_w - 1));
        else
          return sample_t'((table_depth - 1 - p) >> (phase_w - sample_w - 1));
      wave_saw:
        return sample_t'(p >> (phase_w - sample_w));  // p/16
      default:
        return '0;
    endcase
  endfunction

  initial
  begin
    for (int w = 0; w < wave_cnt; w++)
    begin
      for (int p = 0; p < table_depth; p++)
      begin
        rom_mem[w * table_depth + p] = wave_sample(wave_e'(w), p);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      data_out <= '0;
    else
      data_out <= rom_mem[rom_addr.flat];           // flat view of the union
  end

endmodule

`default_nettype wire

// File: design/dds_phase.sv
`default_nettype none

module dds_phase #(
  parameter logic [31:0]                 freq_ctrl  = 32'd65535,  // step per clock
  parameter logic [dds_pkg::phase_w-1:0] phase_ctrl = 12'd1024    // fixed offset
) (
  input  wire logic                  sys_clk,
  input  wire logic                  sys_rst_n,
  input  wire dds_pkg::wave_onehot_t wave_sel,     // one-hot from the key block
  output dds_pkg::rom_addr_u         rom_addr      // registered rom index
);

  import dds_pkg::*;

  logic [31:0]        phase_acc;                    // wraps freely at 2^32
  logic [phase_w-1:0] phase_code;                   // acc msbs plus offset
  wave_e              wave_idx;

  //////////////////////////////////////////////////////////////////////
  // phase accumulator
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      phase_acc <= '0;
    else
      phase_acc <= phase_acc + freq_ctrl;           // overflow is the wrap
  end

  // stage 1, offset added mod 4096
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      phase_code <= '0;
    else
      phase_code <= phase_acc[31 -: phase_w] + phase_ctrl;
  end

  //////////////////////////////////////////////////////////////////////
  // selection decode and address
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (wave_sel)
      sel_sin: wave_idx = wave_sin;
      sel_squ: wave_idx = wave_squ;
      sel_tri: wave_idx = wave_tri;
      sel_saw: wave_idx = wave_saw;
      default: wave_idx = wave_sin;                 // not one-hot, fall back to sine
    endcase
  end

  // stage 2, index packed on top of the phase
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      rom_addr <= '0;
    else
    begin
      rom_addr.fields.wave  <= wave_idx;
      rom_addr.fields.phase <= phase_code;
    end
  end

endmodule

`default_nettype wire

// File: design/key_wave_sel.sv
`default_nettype none

module key_wave_sel #(
  parameter int debounce_cycles = 50000             // cycles a new level must hold
) (
  input  wire logic            sys_clk,
  input  wire logic            sys_rst_n,
  input  wire logic            key_n,              // raw button, active low
  output dds_pkg::wave_onehot_t wave_sel           // current waveform, to leds
);

  import dds_pkg::*;

  // counter never passes debounce_cycles - 1
  localparam int               cnt_w    = $clog2(debounce_cycles + 1);
  // sync stage 0 adds one sample, so the window closes two short of the full count
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_cycles - 2);

  logic [1:0]       key_sync;                       // [0] first flop, [1] safe
  logic             key_db;                         // debounced level
  logic [cnt_w-1:0] stable_cnt;                     // edges with sync[1] != key_db
  logic             accept;
  logic             key_fall;

  //////////////////////////////////////////////////////////////////////
  // synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      key_sync <= 2'b11;                            // released
    else
      key_sync <= {key_sync[0], key_n};
  end

  //////////////////////////////////////////////////////////////////////
  // debounce
  //////////////////////////////////////////////////////////////////////

  // new level seen in both stages and held long enough
  assign accept   = (key_sync[1] != key_db) && (key_sync[0] != key_db)
                    && (stable_cnt == cnt_last);
  assign key_fall = accept && key_db;               // 1 -> 0 is a press

  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      key_db     <= 1'b1;
      stable_cnt <= '0;
    end
    else if (key_sync[1] == key_db)
      stable_cnt <= '0;                             // bounce back, restart window
    else if (accept)
    begin
      key_db     <= key_sync[1];
      stable_cnt <= '0;
    end
    else
      stable_cnt <= stable_cnt + 1'b1;
  end

  // rotate left, saw wraps back to sin
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      wave_sel <= sel_sin;
    else if (key_fall)
      wave_sel <= {wave_sel[2:0], wave_sel[3]};
  end

endmodule

`default_nettype wire

// File: design/dds_pkg.sv
`default_nettype none

package dds_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int phase_w     = 12;                  // phase code bits
  localparam int sample_w    = 8;                   // dac word
  localparam int wave_cnt    = 4;                   // sin, squ, tri, saw
  localparam int rom_aw      = 2 + phase_w;         // wave index on top of phase
  localparam int table_depth = 1 << phase_w;        // entries per waveform
  localparam int rom_depth   = 1 << rom_aw;         // all four tables

  //////////////////////////////////////////////////////////////////////
  // waveform selection
  //////////////////////////////////////////////////////////////////////

  // index order fixes the table order in the rom
  typedef enum logic [1:0] {
    wave_sin = 2'd0,
    wave_squ = 2'd1,
    wave_tri = 2'd2,
    wave_saw = 2'd3
  } wave_e;

  typedef logic [3:0] wave_onehot_t;                // one bit per led

  // led patterns, same bit order as the board
  localparam wave_onehot_t sel_sin = 4'b0001;
  localparam wave_onehot_t sel_squ = 4'b0010;
  localparam wave_onehot_t sel_tri = 4'b0100;
  localparam wave_onehot_t sel_saw = 4'b1000;

  //////////////////////////////////////////////////////////////////////
  // rom address and sample
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    wave_e              wave;                       // table select, msbs
    logic [phase_w-1:0] phase;                      // position in table
  } rom_addr_s;

  // written as fields, read as one flat index
  typedef union packed {
    rom_addr_s         fields;
    logic [rom_aw-1:0] flat;
  } rom_addr_u;

  typedef logic [sample_w-1:0] sample_t;            // unsigned dac code

endpackage

`default_nettype wire
